//--- source/rx_pkg.sv
// receive-path widths and types; assumes a 14-bit ADC on a 16-pad bus, single adc_clk domain
`default_nettype none

package rx_pkg;

	// ========================================================================
	// widths
	// ========================================================================

	localparam int ADC_PHYS_WIDTH = 14;			// converter bits, no overflow
	localparam int ADC_PAD_WIDTH = 16;			// pad bus as routed on the board
	localparam int IQ_WIDTH = ADC_PHYS_WIDTH + 1;	// signed, one bit wider than adc
	localparam int IQ_HALF_WIDTH = 16;			// one half of the packed word
	localparam int DEC_WIDTH = 16;				// decimation factor bits

	// overflow pin of the converter sits on pad 14
	localparam int OVF_PAD = 14;

	// ========================================================================
	// vector types
	// ========================================================================

	typedef logic [ADC_PAD_WIDTH-1:0] adc_pad_t;		// raw pads, scrambled order
	typedef logic [ADC_PHYS_WIDTH-1:0] adc_word_t;		// unsigned sample
	typedef logic signed [IQ_WIDTH-1:0] iq_sample_t;	// signed i or q
	typedef logic signed [IQ_WIDTH-1:0] dc_sub_t;		// signed dc offset
	typedef logic [2*IQ_HALF_WIDTH-1:0] iq_word_t;		// {i, q} packed
	typedef logic [DEC_WIDTH-1:0] dec_fact_t;			// 0 behaves as 1

	// ========================================================================
	// fs/4 mixing phases, cyclic order
	// ========================================================================

	// cos/sin at quarter rate only take the values 1, 0, -1, 0
	typedef enum logic [1:0]
	{
		PH_I_POS = 2'd0,	// i = +x
		PH_Q_POS = 2'd1,	// q = +x
		PH_I_NEG = 2'd2,	// i = -x
		PH_Q_NEG = 2'd3		// q = -x
	} fs4_phase_t;

endpackage

`default_nettype wire

//--- source/adc_capture.sv
// pad capture; pad order fixed by the board routing, pad 1 (clock return) is dropped
`default_nettype none

module adc_capture import rx_pkg::*;
(
	input  logic		adc_clk,
	input  logic		rst_n,			// sync, active low
	input  adc_pad_t	adc_pad,		// straight from the pins
	input  logic		acq_en,			// sequencer acquisition window
	output adc_word_t	sample,			// reordered sample
	output logic		sample_en,		// acq_en aligned with sample
	output logic		adc_ovf_seen	// sticky, reset only
);

	adc_pad_t	pad_q;		// pads, one flop stage
	logic		acq_q;		// window, same stage as pad_q

	// ========================================================================
	// input registers
	// ========================================================================

	always_ff @(posedge adc_clk)
	begin
		pad_q <= adc_pad;	// data path, free running
	end

	always_ff @(posedge adc_clk)
	begin
		if (!rst_n)
			acq_q <= 1'b0;
		else
			acq_q <= acq_en;
	end

	// ========================================================================
	// bit reordering
	// ========================================================================

	// odd bits come from two pads up, even bits straight across
	assign sample = {
		pad_q[15],	// bit 13
		pad_q[12],	// bit 12
		pad_q[13],	// bit 11
		pad_q[10],	// bit 10
		pad_q[11],	// bit 9
		pad_q[8],	// bit 8
		pad_q[9],	// bit 7
		pad_q[6],	// bit 6
		pad_q[7],	// bit 5
		pad_q[4],	// bit 4
		pad_q[5],	// bit 3
		pad_q[2],	// bit 2
		pad_q[3],	// bit 1
		pad_q[0]	// bit 0
	};

	assign sample_en = acq_q;

	// ========================================================================
	// overflow flag
	// ========================================================================

	// overflow outside the window is ignored, adc may be clipping on tx
	always_ff @(posedge adc_clk)
	begin
		if (!rst_n)
			adc_ovf_seen <= 1'b0;
		else if (acq_q && pad_q[OVF_PAD])
			adc_ovf_seen <= 1'b1;		// held until next reset
	end

endmodule

`default_nettype wire

//--- source/fs4_downconverter.sv
// quarter-rate mixer, no filtering; phase restarts every window, negation wraps at 15 bits
`default_nettype none

module fs4_downconverter import rx_pkg::*;
(
	input  logic		adc_clk,
	input  logic		rst_n,
	input  adc_word_t	sample,		// unsigned adc sample
	input  logic		sample_en,	// level, high during acquisition
	input  dc_sub_t		dc_sub,		// signed offset, static while idle
	output iq_sample_t	data_i,
	output iq_sample_t	data_q,
	output logic		iq_valid	// one per enabled sample
);

	dc_sub_t	dc_sub_q;		// offset, registered once
	iq_sample_t	x;				// sample minus offset
	iq_sample_t	neg_x;
	fs4_phase_t	phase;			// current mixing phase
	fs4_phase_t	phase_nxt;

	// ========================================================================
	// offset removal
	// ========================================================================

	always_ff @(posedge adc_clk)
	begin
		dc_sub_q <= dc_sub;
	end

	// zero-extend, then subtract; both sides are 15 bits so it wraps
	assign x = iq_sample_t'({1'b0, sample}) - dc_sub_q;
	assign neg_x = -x;		// -(-16384) stays -16384

	// ========================================================================
	// phase sequencer
	// ========================================================================

	always_comb
	begin
		case (phase)
			PH_I_POS: phase_nxt = PH_Q_POS;
			PH_Q_POS: phase_nxt = PH_I_NEG;
			PH_I_NEG: phase_nxt = PH_Q_NEG;
			default: phase_nxt = PH_I_POS;
		endcase
	end

	always_ff @(posedge adc_clk)
	begin
		if (!rst_n)
			phase <= PH_I_POS;
		else if (sample_en)
			phase <= phase_nxt;
		else
			phase <= PH_I_POS;	// align to window start
	end

	// ========================================================================
	// mixer outputs
	// ========================================================================

	always_ff @(posedge adc_clk)
	begin
		case (phase)
			PH_I_POS:
			begin
				data_i <= x;
				data_q <= '0;
			end
			PH_Q_POS:
			begin
				data_i <= '0;
				data_q <= x;
			end
			PH_I_NEG:
			begin
				data_i <= neg_x;
				data_q <= '0;
			end
			default:
			begin
				data_i <= '0;
				data_q <= neg_x;	// PH_Q_NEG
			end
		endcase
	end

	always_ff @(posedge adc_clk)
	begin
		if (!rst_n)
			iq_valid <= 1'b0;
		else
			iq_valid <= sample_en;
	end

endmodule

`default_nettype wire

//--- source/iq_decimator.sv
// i/q packer and decimator; no back-pressure, dec_fact must be static while samples flow
`default_nettype none

module iq_decimator import rx_pkg::*;
(
	input  logic		adc_clk,
	input  logic		rst_n,
	input  iq_sample_t	data_i,
	input  iq_sample_t	data_q,
	input  logic		iq_valid,	// strobe, consumed the same cycle
	input  dec_fact_t	dec_fact,	// keep every nth pair, 0 same as 1
	output iq_word_t	rx_data,	// {i, q}, each sign-extended to 16
	output logic		rx_valid
);

	dec_fact_t	dec_fact_q;
	dec_fact_t	eff_fact;		// factor with 0 mapped to 1
	dec_fact_t	cnt;			// pairs seen since last output
	dec_fact_t	cnt_inc;
	logic		hit;			// this pair goes out

	// ========================================================================
	// factor register
	// ========================================================================

	always_ff @(posedge adc_clk)
	begin
		dec_fact_q <= dec_fact;
	end

	assign eff_fact = (dec_fact_q == '0) ? dec_fact_t'(1) : dec_fact_q;

	// ========================================================================
	// pair counter
	// ========================================================================

	assign cnt_inc = cnt + dec_fact_t'(1);
	// >= so a factor lowered below a carried count still restarts cleanly
	assign hit = iq_valid && (cnt_inc >= eff_fact);

	always_ff @(posedge adc_clk)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (hit)
			cnt <= '0;
		else if (iq_valid)
			cnt <= cnt_inc;		// carries over between windows
	end

	// ========================================================================
	// output word
	// ========================================================================

	always_ff @(posedge adc_clk)
	begin
		if (hit)
			rx_data <= {
				{(IQ_HALF_WIDTH-IQ_WIDTH){data_i[IQ_WIDTH-1]}}, data_i,	// upper half
				{(IQ_HALF_WIDTH-IQ_WIDTH){data_q[IQ_WIDTH-1]}}, data_q	// lower half
			};
	end

	always_ff @(posedge adc_clk)
	begin
		if (!rst_n)
			rx_valid <= 1'b0;
		else
			rx_valid <= hit;	// single cycle
	end

endmodule

`default_nettype wire

//--- source/rx_front_top.sv
// adc receive front end; pad to rx_valid is 3 cycles, change dc_sub/dec_fact only while idle
`default_nettype none

module rx_front_top import rx_pkg::*;
(
	input  logic		adc_clk,
	input  logic		rst_n,			// sync, active low
	input  adc_pad_t	adc_pad,		// raw adc pads
	input  logic		acq_en,			// acquisition window from sequencer
	input  dc_sub_t		dc_sub,			// dc offset to remove
	input  dec_fact_t	dec_fact,		// output every nth pair
	output iq_word_t	rx_data,		// {i, q}
	output logic		rx_valid,
	output logic		adc_ovf_seen	// sticky overflow
);

	// ========================================================================
	// internal nets
	// ========================================================================

	adc_word_t	sample;			// capture -> mixer
	logic		sample_en;
	iq_sample_t	data_i;			// mixer -> decimator
	iq_sample_t	data_q;
	logic		iq_valid;

	// stage 1, pads in
	adc_capture u_capture
	(
		.adc_clk		(adc_clk),
		.rst_n			(rst_n),
		.adc_pad		(adc_pad),
		.acq_en			(acq_en),
		.sample			(sample),
		.sample_en		(sample_en),
		.adc_ovf_seen	(adc_ovf_seen)
	);

	// stage 2, offset and fs/4 mix
	fs4_downconverter u_dconv
	(
		.adc_clk	(adc_clk),
		.rst_n		(rst_n),
		.sample		(sample),
		.sample_en	(sample_en),
		.dc_sub		(dc_sub),
		.data_i		(data_i),
		.data_q		(data_q),
		.iq_valid	(iq_valid)
	);

	// stage 3, pack and decimate
	iq_decimator u_decim
	(
		.adc_clk	(adc_clk),
		.rst_n		(rst_n),
		.data_i		(data_i),
		.data_q		(data_q),
		.iq_valid	(iq_valid),
		.dec_fact	(dec_fact),
		.rx_data	(rx_data),
		.rx_valid	(rx_valid)
	);

endmodule

`default_nettype wire

//--- sim/rx_front_chk.sv
// downconverter assertions, bound to every fs4_downconverter; relies on its internal phase signal
`default_nettype none

module rx_front_chk import rx_pkg::*;
(
	input  logic		adc_clk,
	input  logic		rst_n,
	input  logic		sample_en,
	input  logic		iq_valid,
	input  iq_sample_t	data_i,
	input  iq_sample_t	data_q,
	input  fs4_phase_t	phase
);
	timeunit 1ns;
	timeprecision 100ps;

	// ========================================================================
	// properties
	// ========================================================================

	// one reset cycle clears the strobe
	a_valid_rst: assert property (@(posedge adc_clk) !rst_n |=> !iq_valid)
		else $error("iq_valid high after a reset cycle");

	a_phase_restart: assert property (@(posedge adc_clk) disable iff (!rst_n)
		!sample_en |=> phase == PH_I_POS)	// window start always i+
		else $error("phase not back at PH_I_POS after sample_en low");

	// quarter-rate mixing never drives i and q together
	a_one_zero: assert property (@(posedge adc_clk) disable iff (!rst_n)
		iq_valid |-> (data_i == '0 || data_q == '0))
		else $error("data_i and data_q both nonzero on iq_valid");

endmodule

bind fs4_downconverter rx_front_chk u_chk
(
	.adc_clk	(adc_clk),
	.rst_n		(rst_n),
	.sample_en	(sample_en),
	.iq_valid	(iq_valid),
	.data_i		(data_i),
	.data_q		(data_q),
	.phase		(phase)
);

`default_nettype wire

//--- sim/rx_front_tb.sv
// testbench for the adc front end; dc_sub and dec_fact only change while acq_en is low
`default_nettype none

module rx_front_tb import rx_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic		adc_clk;
	logic		rst_n;
	adc_pad_t	adc_pad;
	logic		acq_en;
	dc_sub_t	dc_sub;
	dec_fact_t	dec_fact;
	iq_word_t	rx_data;
	logic		rx_valid;
	logic		adc_ovf_seen;

	logic [31:0]	lfsr;		// galois state
	iq_word_t	exp_q[$];		// expected words in output order
	int			dec_cnt;		// model pair count across windows
	int			ph_idx;			// model phase (0 i+ 1 q+ 2 i- 3 q-)
	logic		prev_en;		// acq_en of the last driven cycle

	rx_front_top uut
	(
		.adc_clk		(adc_clk),
		.rst_n			(rst_n),
		.adc_pad		(adc_pad),
		.acq_en			(acq_en),
		.dc_sub			(dc_sub),
		.dec_fact		(dec_fact),
		.rx_data		(rx_data),
		.rx_valid		(rx_valid),
		.adc_ovf_seen	(adc_ovf_seen)
	);

	initial
	begin
		adc_clk = 1'b0;
		forever #50 adc_clk = ~adc_clk;		// 10 MHz
	end

	// ========================================================================
	// stimulus source and reference model
	// ========================================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);	// x^32+x^22+x^2+x+1
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// expected word for one pad sample at mixing phase ph
	function automatic iq_word_t mix_ref(input adc_pad_t pad, input dc_sub_t dcs, input int ph);
		adc_word_t	s;
		iq_sample_t	x;
		iq_sample_t	i_v;
		iq_sample_t	q_v;
		s[0] = pad[0];
		for (int k = 1; k < ADC_PHYS_WIDTH; k++)
			s[k] = (k % 2 == 1) ? pad[k+2] : pad[k];		// odd bits two pads up
		x = iq_sample_t'(int'(s) - int'(dcs));		// wraps at 15 bits
		i_v = '0;
		q_v = '0;
		case (ph)
			0: i_v = x;
			1: q_v = x;
			2: i_v = iq_sample_t'(-int'(x));
			default: q_v = iq_sample_t'(-int'(x));
		endcase
		return {IQ_HALF_WIDTH'(i_v), IQ_HALF_WIDTH'(q_v)};	// sign-extended halves
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
			abort_run($sformatf("[FAIL] t=%0t %s expected %h actual %h",
				$time, name, exp, act));
	endtask

	// ========================================================================
	// drivers
	// ========================================================================

	task automatic apply_reset();
		rst_n = 1'b0;
		acq_en = 1'b0;
		repeat (10) @(posedge adc_clk);
		#10;
		rst_n = 1'b1;
		dec_cnt = 0;	// decimation count restarts with the dut
		prev_en = 1'b0;
	endtask

	// ovf forces pad 14 high; otherwise low in the window and random outside
	task automatic drive_cycle(input logic en, input logic ovf);
		adc_pad_t pad;
		@(posedge adc_clk);
		#10;
		pad = adc_pad_t'(take_bits(ADC_PAD_WIDTH));
		if (ovf)
			pad[OVF_PAD] = 1'b1;
		else if (en)
			pad[OVF_PAD] = 1'b0;
		adc_pad = pad;
		acq_en = en;
		if (en)
		begin
			ph_idx = prev_en ? (ph_idx + 1) % 4 : 0;	// restart at i+ per window
			dec_cnt = dec_cnt + 1;
			if (dec_cnt >= ((dec_fact == '0) ? 1 : int'(dec_fact)))
			begin
				exp_q.push_back(mix_ref(pad, dc_sub, ph_idx));
				dec_cnt = 0;
			end
		end
		prev_en = en;
	endtask

	task automatic idle(input int n, input logic ovf);
		for (int i = 0; i < n; i++)
			drive_cycle(1'b0, ovf);
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < max_cycles)
		begin
			@(posedge adc_clk);
			n++;
		end
		if (exp_q.size() != 0)
			abort_run($sformatf("timeout: %0d expected words never reached rx_data",
				exp_q.size()));
	endtask

	// ovf_at = -1 for a window without overflow
	task automatic run_window(input int len, input int ovf_at);
		for (int i = 0; i < len; i++)
			drive_cycle(1'b1, i == ovf_at);
		idle(4, 1'b0);
		wait_drain(20);
	endtask

	// ========================================================================
	// output comparison at mid-cycle
	// ========================================================================

	initial
	begin
		forever
		begin
			@(negedge adc_clk);
			if (rst_n === 1'b1 && rx_valid !== 1'b0)
			begin
				if (exp_q.size() == 0)
					check_value("rx_valid", 0, rx_valid);	// strobe with nothing queued
				else
					check_value("rx_data", exp_q.pop_front(), rx_data);
			end
		end
	end

	// ========================================================================
	// sequence
	// ========================================================================

	initial
	begin
		adc_pad = '0;
		acq_en = 1'b0;
		dc_sub = '0;
		dec_fact = dec_fact_t'(1);
		rst_n = 1'b0;
		lfsr = 32'd72048;
		dec_cnt = 0;
		ph_idx = 0;
		prev_en = 1'b0;
		apply_reset();
		idle(30, 1'b0);		// random pads and no window
		check_value("adc_ovf_seen", 0, adc_ovf_seen);
		for (int w = 0; w < 3; w++)
			run_window(8 + take_bits(4), -1);	// factor 1 and no offset
		for (int w = 0; w < 3; w++)
		begin
			dc_sub = dc_sub_t'(take_bits(IQ_WIDTH));
			idle(4, 1'b0);
			run_window(6 + take_bits(4), -1);
		end
		dec_fact = dec_fact_t'(3);
		idle(4, 1'b0);
		for (int w = 0; w < 4; w++)
			run_window(5 + take_bits(3), -1);	// count carries between windows
		dec_fact = '0;
		idle(4, 1'b0);
		for (int w = 0; w < 2; w++)
			run_window(5 + take_bits(3), -1);
		idle(6, 1'b1);		// overflow pin high while idle
		idle(3, 1'b0);
		check_value("adc_ovf_seen", 0, adc_ovf_seen);
		run_window(6, 2);
		check_value("adc_ovf_seen", 1, adc_ovf_seen);
		run_window(6, -1);
		check_value("adc_ovf_seen", 1, adc_ovf_seen);	// sticky
		apply_reset();
		check_value("adc_ovf_seen", 0, adc_ovf_seen);
		if (exp_q.size() != 0)
			abort_run("words left in the expected queue at the end of the run");
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- build.f
source/rx_pkg.sv
source/adc_capture.sv
source/fs4_downconverter.sv
source/iq_decimator.sv
source/rx_front_top.sv
sim/rx_front_chk.sv
sim/rx_front_tb.sv

//--- Bender.yml
package:
  name: rx_front

sources:
  - files:
      - source/rx_pkg.sv
      - source/adc_capture.sv
      - source/fs4_downconverter.sv
      - source/iq_decimator.sv
      - source/rx_front_top.sv
  - target: simulation
    files:
      - sim/rx_front_chk.sv
      - sim/rx_front_tb.sv
